// ==== logic/dogScenePkg.sv ====
package dogScenePkg;

    // scaled raster, pixel clocks per line and lines per frame
    localparam logic [7:0] HActive    = 8'd160;
    localparam logic [7:0] HTotal     = 8'd200;
    localparam logic [7:0] HSyncStart = 8'd168;
    localparam logic [7:0] HSyncEnd   = 8'd184;
    localparam logic [7:0] VActive    = 8'd120;
    localparam logic [7:0] VTotal     = 8'd131;
    localparam logic [7:0] VSyncStart = 8'd122;
    localparam logic [7:0] VSyncEnd   = 8'd124;

    localparam int SpriteSize = 8;   // square sprite, 8x8 pixels
    localparam int RomWords   = 72;  // 9 frames of 8 rows

    // scene layout and motion
    localparam logic [7:0] HomeX    = 8'd8;
    localparam logic [7:0] HomeY    = 8'd96;
    localparam logic [7:0] StepX    = 8'd4;
    localparam logic [7:0] JumpRise = 8'd12;
    localparam logic [7:0] GrassY   = 8'd104;
    localparam int WalkLoops   = 3;
    localparam int SniffRounds = 2;
    localparam int AnimDiv     = 2;  // video frames per animation step

    localparam logic [11:0] SkyColor   = 12'h6BF;
    localparam logic [11:0] GrassColor = 12'h3A2;

    // entry 0 is never drawn
    localparam logic [11:0] Palette [4] = '{12'h000, 12'h852, 12'hDB8, 12'h111};

    // value equals the frame number in the sprite ROM
    typedef enum logic [3:0] {
        Stand, Walk1, Walk2, Walk3, Walk4, Sniff1, Sniff2, Surprised, Jump
    } frameCode;

endpackage

// ==== logic/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming (
    input  logic       Clk,
    input  logic       arstN,
    output logic [7:0] hCount,
    output logic [7:0] vCount,
    output logic       hSync,
    output logic       vSync,
    output logic       active,
    output logic       frameStart
);

    logic lineEnd;

    assign lineEnd = (hCount == dogScenePkg::HTotal - 8'd1);

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hCount <= '0;
            vCount <= '0;
        end
        else if (lineEnd)
        begin
            hCount <= '0;
            if (vCount == dogScenePkg::VTotal - 8'd1)
                vCount <= '0;  // wrap to top of frame
            else
                vCount <= vCount + 8'd1;
        end
        else
        begin
            hCount <= hCount + 8'd1;
        end
    end

    // sync pulses are active low
    assign hSync = !((hCount >= dogScenePkg::HSyncStart) && (hCount < dogScenePkg::HSyncEnd));
    assign vSync = !((vCount >= dogScenePkg::VSyncStart) && (vCount < dogScenePkg::VSyncEnd));

    assign active = (hCount < dogScenePkg::HActive) && (vCount < dogScenePkg::VActive);

    // first clock of the first blank line
    assign frameStart = (hCount == 8'd0) && (vCount == dogScenePkg::VActive);

    vCountRange: assert property (@(posedge Clk) disable iff (!arstN)
        vCount < dogScenePkg::VTotal);

endmodule

// ==== logic/dogControl.sv ====
`timescale 1ns/1ps

module dogControl (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic                  frameStart,
    output logic [7:0]            dogX,
    output logic [7:0]            dogY,
    output dogScenePkg::frameCode frame,
    output logic                  visible
);

    typedef enum logic [3:0] {
        stHome, stWalk1, stWalk2, stWalk3, stWalk4, stSniff1, stSniff2,
        stSurprised, stJump1, stJump2, stHide
    } sceneState;

    sceneState state;
    sceneState nextState;
    dogScenePkg::frameCode nextFrame;
    logic [1:0] divCnt;
    logic [1:0] walkCnt;
    logic [1:0] sniffCnt;
    logic stepNow;

    assign stepNow = frameStart && (divCnt == dogScenePkg::AnimDiv - 1);

    always_comb
    begin
        nextState = state;
        unique case (state)
            stHome:      nextState = stWalk1;
            stWalk1:     nextState = stWalk2;
            stWalk2:     nextState = stWalk3;
            stWalk3:     nextState = stWalk4;
            stWalk4:     nextState = (walkCnt == dogScenePkg::WalkLoops - 1) ? stSniff1 : stWalk1;
            stSniff1:    nextState = stSniff2;
            stSniff2:    nextState = (sniffCnt == dogScenePkg::SniffRounds - 1) ? stSurprised
                                                                                : stSniff1;
            stSurprised: nextState = stJump1;
            stJump1:     nextState = stJump2;
            stJump2:     nextState = stHide;
            stHide:      nextState = stHide;  // stays behind the grass until reset
            default:     nextState = stHome;
        endcase
    end

    // sprite frame shown while in the next state
    always_comb
    begin
        case (nextState)
            stWalk1:                   nextFrame = dogScenePkg::Walk1;
            stWalk2:                   nextFrame = dogScenePkg::Walk2;
            stWalk3:                   nextFrame = dogScenePkg::Walk3;
            stWalk4:                   nextFrame = dogScenePkg::Walk4;
            stSniff1:                  nextFrame = dogScenePkg::Sniff1;
            stSniff2:                  nextFrame = dogScenePkg::Sniff2;
            stSurprised:               nextFrame = dogScenePkg::Surprised;
            stJump1, stJump2, stHide:  nextFrame = dogScenePkg::Jump;
            default:                   nextFrame = dogScenePkg::Stand;
        endcase
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            divCnt   <= '0;
            walkCnt  <= '0;
            sniffCnt <= '0;
            state    <= stHome;
            dogX     <= dogScenePkg::HomeX;
            dogY     <= dogScenePkg::HomeY;
            frame    <= dogScenePkg::Stand;
            visible  <= 1'b1;
        end
        else if (frameStart)
        begin
            divCnt <= stepNow ? 2'd0 : divCnt + 2'd1;
            if (stepNow)
            begin
                state   <= nextState;
                frame   <= nextFrame;
                visible <= (nextState != stHide);
                if (state == stWalk4)
                    walkCnt <= walkCnt + 2'd1;  // one full walk cycle done
                if (state == stSniff2)
                    sniffCnt <= sniffCnt + 2'd1;
                if (nextState inside {stWalk1, stWalk2, stWalk3, stWalk4})
                    dogX <= dogX + dogScenePkg::StepX;
                if (nextState inside {stJump1, stJump2})
                    dogY <= dogY - dogScenePkg::JumpRise;  // screen y grows downward
            end
        end
    end

    // scene only moves in blanking, right after the frame pulse
    stepAfterFrame: assert property (@(posedge Clk) disable iff (!arstN)
        $changed(state) |-> $past(frameStart));

    dogOnScreen: assert property (@(posedge Clk) disable iff (!arstN)
        dogX <= dogScenePkg::HActive - dogScenePkg::SpriteSize);

endmodule

// ==== logic/spriteRom.sv ====
`timescale 1ns/1ps

module spriteRom (
    input  logic       Clk,
    input  logic [9:0] addr,      // frame, row, column
    output logic [1:0] colorIdx
);

    logic [15:0] rom [dogScenePkg::RomWords];
    logic [15:0] rowWord;
    logic [2:0]  col;

    initial
    begin
        $readmemh("dogSprites.mem", rom);
    end

    assign rowWord = rom[addr[9:3]];  // frame * 8 + row
    assign col     = addr[2:0];

    // column 0 sits in the top two bits of the row
    always_ff @(posedge Clk)
    begin
        colorIdx <= rowWord[{~col, 1'b0} +: 2];
    end

endmodule

// ==== logic/pixelPipe.sv ====
`timescale 1ns/1ps

module pixelPipe (
    input  logic                  Clk,
    input  logic                  arstN,
    input  logic [7:0]            hCount,
    input  logic [7:0]            vCount,
    input  logic                  hSync,
    input  logic                  vSync,
    input  logic                  active,
    input  logic [7:0]            dogX,
    input  logic [7:0]            dogY,
    input  dogScenePkg::frameCode frame,
    input  logic                  visible,
    output logic [11:0]           rgb,
    output logic                  hSyncOut,
    output logic                  vSyncOut
);

    logic [7:0]  relX;
    logic [7:0]  relY;
    logic        inWindow;
    logic [9:0]  romAddr;
    logic [1:0]  colorIdx;
    logic        hit1;
    logic        active1;
    logic        hSync1;
    logic        vSync1;
    logic        hit2;
    logic        active2;
    logic        hSync2;
    logic        vSync2;
    logic [11:0] bg1;
    logic [11:0] bg2;

    // offsets wrap when left of or above the sprite, so one compare covers both sides
    assign relX = hCount - dogX;
    assign relY = vCount - dogY;
    assign inWindow = visible && (relX < dogScenePkg::SpriteSize)
                   && (relY < dogScenePkg::SpriteSize)
                   && (vCount < dogScenePkg::GrassY);  // grass hides the feet

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hit1    <= 1'b0;
            active1 <= 1'b0;
            hSync1  <= 1'b1;
            vSync1  <= 1'b1;
            hit2    <= 1'b0;
            active2 <= 1'b0;
            hSync2  <= 1'b1;
            vSync2  <= 1'b1;
        end
        else
        begin
            hit1    <= inWindow;
            active1 <= active;
            hSync1  <= hSync;
            vSync1  <= vSync;
            hit2    <= hit1;     // second register lines up with the ROM output
            active2 <= active1;
            hSync2  <= hSync1;
            vSync2  <= vSync1;
        end
    end

    always_ff @(posedge Clk)
    begin
        romAddr <= {frame, relY[2:0], relX[2:0]};
        bg1     <= (vCount < dogScenePkg::GrassY) ? dogScenePkg::SkyColor
                                                  : dogScenePkg::GrassColor;
        bg2     <= bg1;
    end

    spriteRom romInst (
        .Clk      (Clk),
        .addr     (romAddr),
        .colorIdx (colorIdx)
    );

    always_comb
    begin
        if (!active2)
            rgb = '0;
        else if (hit2 && (colorIdx != 2'd0))
            rgb = dogScenePkg::Palette[colorIdx];
        else
            rgb = bg2;  // background shows through index 0
    end

    assign hSyncOut = hSync2;
    assign vSyncOut = vSync2;

endmodule

// ==== logic/dogScene.sv ====
`timescale 1ns/1ps

module dogScene (
    input  logic        Clk,
    input  logic        arstN,
    output logic [11:0] rgb,
    output logic        hSyncOut,
    output logic        vSyncOut
);

    logic [7:0] hCount;
    logic [7:0] vCount;
    logic       hSync;
    logic       vSync;
    logic       active;
    logic       frameStart;
    logic [7:0] dogX;
    logic [7:0] dogY;
    logic       visible;
    dogScenePkg::frameCode frame;

    vgaTiming timingInst (
        .Clk        (Clk),
        .arstN      (arstN),
        .hCount     (hCount),
        .vCount     (vCount),
        .hSync      (hSync),
        .vSync      (vSync),
        .active     (active),
        .frameStart (frameStart)
    );

    dogControl controlInst (
        .Clk        (Clk),
        .arstN      (arstN),
        .frameStart (frameStart),
        .dogX       (dogX),
        .dogY       (dogY),
        .frame      (frame),
        .visible    (visible)
    );

    // two clocks from counters to pins
    pixelPipe pipeInst (
        .Clk      (Clk),
        .arstN    (arstN),
        .hCount   (hCount),
        .vCount   (vCount),
        .hSync    (hSync),
        .vSync    (vSync),
        .active   (active),
        .dogX     (dogX),
        .dogY     (dogY),
        .frame    (frame),
        .visible  (visible),
        .rgb      (rgb),
        .hSyncOut (hSyncOut),
        .vSyncOut (vSyncOut)
    );

endmodule

// ==== test/dogSceneTb.sv ====
`timescale 1ns/1ps

module dogSceneTb;

    logic        Clk;
    logic        arstN;
    logic [11:0] rgb;
    logic        hSyncOut;
    logic        vSyncOut;

    logic [15:0] spriteMem [dogScenePkg::RomWords];
    int   cycle = 0;
    int   curH = 0;            // raster position of the pixel now on the outputs
    int   curV = 0;
    int   stepN = 0;           // scene steps taken since reset
    int   pulseCnt = 0;
    bit   synced = 1'b0;       // model raster locked to vSyncOut
    logic lastVs = 1'b1;
    int   mismatches = 0;
    int   otherErrors = 0;
    logic [11:0] expRgb;
    logic inActive;
    logic expHs;
    logic expVs;
    logic dogHidden;

    dogScene UUT (
        .Clk      (Clk),
        .arstN    (arstN),
        .rgb      (rgb),
        .hSyncOut (hSyncOut),
        .vSyncOut (vSyncOut)
    );

    // first hidden step: all walks and sniffs, then surprise and two jumps
    function automatic int hideStep();
        return 4 * dogScenePkg::WalkLoops + 2 * dogScenePkg::SniffRounds + 4;
    endfunction

    function automatic logic [11:0] expectedPixel(input int h, input int v, input int n);
        int walkEnd;
        int sniffEnd;
        int x;
        int y;
        int frm;
        int idx;
        logic [11:0] bg;
        walkEnd  = 4 * dogScenePkg::WalkLoops;
        sniffEnd = walkEnd + 2 * dogScenePkg::SniffRounds;
        if (h >= dogScenePkg::HActive || v >= dogScenePkg::VActive)
            return 12'h000;
        bg = (v < dogScenePkg::GrassY) ? dogScenePkg::SkyColor : dogScenePkg::GrassColor;
        if (n >= hideStep())
            return bg;
        x = dogScenePkg::HomeX + dogScenePkg::StepX * ((n < walkEnd) ? n : walkEnd);
        y = dogScenePkg::HomeY;
        if (n > sniffEnd + 1)
            y = y - dogScenePkg::JumpRise * ((n > sniffEnd + 2) ? 2 : 1);  // Jump1, Jump2
        if (n == 0)
            frm = dogScenePkg::Stand;
        else if (n <= walkEnd)
            frm = dogScenePkg::Walk1 + (n - 1) % 4;
        else if (n <= sniffEnd)
            frm = dogScenePkg::Sniff1 + (n - walkEnd - 1) % 2;
        else if (n == sniffEnd + 1)
            frm = dogScenePkg::Surprised;
        else
            frm = dogScenePkg::Jump;
        if (h < x || h >= x + dogScenePkg::SpriteSize || v < y
            || v >= y + dogScenePkg::SpriteSize || v >= dogScenePkg::GrassY)
            return bg;
        idx = (spriteMem[frm * 8 + v - y] >> (14 - 2 * (h - x))) & 3;
        return (idx == 0) ? bg : dogScenePkg::Palette[idx];
    endfunction

    assign inActive  = (curH < dogScenePkg::HActive) && (curV < dogScenePkg::VActive);
    assign expRgb    = expectedPixel(curH, curV, stepN);
    assign expHs     = !(curH >= dogScenePkg::HSyncStart && curH < dogScenePkg::HSyncEnd);
    assign expVs     = !(curV >= dogScenePkg::VSyncStart && curV < dogScenePkg::VSyncEnd);
    assign dogHidden = (stepN >= hideStep());

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(posedge Clk)
        cycle <= cycle + 1;

    // raster and scene model, one output pixel per clock
    always @(posedge Clk)
    begin
        lastVs <= vSyncOut;
        if (!arstN)
        begin
            synced   <= 1'b0;
            stepN    <= 0;
            pulseCnt <= 0;
        end
        else if (!synced)
        begin
            if (lastVs && !vSyncOut)
            begin
                synced   <= 1'b1;
                curH     <= 1;                        // next output pixel is (1, VSyncStart)
                curV     <= dogScenePkg::VSyncStart;
                pulseCnt <= 1;                        // frame 0 already had its frame pulse
            end
        end
        else
        begin
            if (curH == dogScenePkg::HTotal - 1)
            begin
                curH <= 0;
                curV <= (curV == dogScenePkg::VTotal - 1) ? 0 : curV + 1;
            end
            else
            begin
                curH <= curH + 1;
            end
            if (curH == 0 && curV == dogScenePkg::VActive)
            begin
                if (pulseCnt == dogScenePkg::AnimDiv - 1)
                begin
                    pulseCnt <= 0;
                    stepN    <= stepN + 1;
                end
                else
                begin
                    pulseCnt <= pulseCnt + 1;
                end
            end
        end
    end

    syncOk: assert property (@(posedge Clk) disable iff (!arstN)
        synced |-> (hSyncOut == expHs) && (vSyncOut == expVs))
    else
    begin
        mismatches++;
        $display("Mismatch at %0t: syncs h=%b v=%b at (%0d,%0d)", $time,
                 $sampled(hSyncOut), $sampled(vSyncOut), $sampled(curH), $sampled(curV));
    end

    blankOk: assert property (@(posedge Clk) disable iff (!arstN)
        (synced && !inActive) |-> (rgb == 12'h000))
    else
    begin
        mismatches++;
        $display("Mismatch at %0t: blank pixel (%0d,%0d) shows %h", $time,
                 $sampled(curH), $sampled(curV), $sampled(rgb));
    end

    pixelOk: assert property (@(posedge Clk) disable iff (!arstN)
        (synced && inActive) |-> (rgb == expRgb))
    else
    begin
        mismatches++;
        $display("Mismatch at %0t: pixel (%0d,%0d) step %0d is %h, expected %h", $time,
                 $sampled(curH), $sampled(curV), $sampled(stepN), $sampled(rgb),
                 $sampled(expRgb));
    end

    hiddenOk: assert property (@(posedge Clk) disable iff (!arstN)
        (synced && inActive && dogHidden)
        |-> (rgb == dogScenePkg::SkyColor || rgb == dogScenePkg::GrassColor))
    else
    begin
        mismatches++;
        $display("Mismatch at %0t: hidden dog still drawn at (%0d,%0d)", $time,
                 $sampled(curH), $sampled(curV));
    end

    resetOk: assert property (@(posedge Clk)
        (!arstN && cycle > 1) |-> (rgb == 12'h000 && hSyncOut && vSyncOut))
    else
    begin
        mismatches++;
        $display("Mismatch at %0t: outputs not idle during reset", $time);
    end

    task automatic printCounts();
        $display("Error counts: %0d mismatches, %0d other errors", mismatches, otherErrors);
    endtask

    // 23 steps of 2 frames at 26,200 clocks each, plus the reset replay
    initial
    begin
        while (cycle < 1400000)
            @(posedge Clk);
        otherErrors++;
        $display("Timeout: the scene did not reach its last step in time");
        printCounts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        $readmemh("logic/dogSprites.mem", spriteMem);
        arstN = 1'b0;
        repeat (8) @(posedge Clk);
        #1 arstN = 1'b1;
        wait (stepN == hideStep() + 2);  // a few hidden frames after the jump
        @(posedge Clk);
        #1 arstN = 1'b0;
        repeat (8) @(posedge Clk);
        #1 arstN = 1'b1;
        wait (stepN == 1);  // Stand frame at home checked after relock
        @(posedge Clk);
        printCounts();
        if (mismatches == 0 && otherErrors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== logic/dogSprites.mem ====
// one 16-bit row per line, column 0 in the top two bits, 2-bit colour index per pixel
// frames Stand, Walk1..Walk4, Sniff1, Sniff2, Surprised, Jump with eight rows each
0014
0077
4055
5560
1A50
1550
1010
1010
0014
0077
4055
5560
1A50
1550
1040
4040
0014
0077
4055
5560
1A50
1550
0410
0410
0014
0077
4055
5560
1A50
1550
1004
0401
0014
0077
0055
5560
1A50
1550
1010
1010
0000
0000
4000
5550
1A54
1577
1010
1010
0000
0000
4000
5550
1A55
1574
1010
1010
0044
0054
40DF
5554
1A50
1550
4004
4004
0005
001D
0057
0164
16A0
5540
4400
4000

// ==== dogScene.f ====
logic/dogScenePkg.sv
logic/vgaTiming.sv
logic/dogControl.sv
logic/spriteRom.sv
logic/pixelPipe.sv
logic/dogScene.sv
test/dogSceneTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build the dog scene testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

# the sprite ROM opens its data file from the working directory
cp -f logic/dogSprites.mem dogSprites.mem

verilator --binary --timing --assert -Wno-fatal --top-module dogSceneTb \
    -f dogScene.f --Mdir obj_dir -o simDogScene

./obj_dir/simDogScene | tee sim.log

if grep -q "SIMULATION PASSED" sim.log
then
    exit 0
fi
exit 1
